/* common/axi_pkg.sv */
package axi_pkg;

   // Bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // AXI4 burst length field, L means L+1 beats
   localparam int LEN_W = 8;

   // Full-width beats only
   localparam logic [2:0] AXI_SIZE = 3'($clog2(STRB_W));

   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // Normal non-cacheable bufferable
   localparam logic [3:0] AXI_CACHE_VAL = 4'b0011;

   // Unprivileged, non-secure, data access
   localparam logic [2:0] AXI_PROT_VAL = 3'b010;

   // Response codes
   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // AW and AR share one layout
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
      logic [2:0]        size;
      logic [1:0]        burst;
      logic [3:0]        cache;
      logic [2:0]        prot;
   } axi_ax_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } axi_w_t;

   typedef struct packed {
      resp_t resp;
   } axi_b_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      resp_t             resp;
      logic              last;
   } axi_r_t;

endpackage

/* iob2axi/iob2axi_wr.sv */
`timescale 1ns/1ns

module iob2axi_wr (
   input  logic                       clk,
   input  logic                       rst,

   // Burst control
   input  logic [axi_pkg::LEN_W-1:0]  length,
   output logic                       wr_ready,
   output logic                       error,

   // Native write beats
   input  logic                       valid,
   input  logic [axi_pkg::ADDR_W-1:0] addr,
   input  logic [axi_pkg::DATA_W-1:0] wdata,
   input  logic [axi_pkg::STRB_W-1:0] wstrb,
   output logic                       ready,

   // AXI write master
   output axi_pkg::axi_ax_t           m_aw,
   output logic                       m_awvalid,
   input  logic                       m_awready,
   output axi_pkg::axi_w_t            m_w,
   output logic                       m_wvalid,
   input  logic                       m_wready,
   input  axi_pkg::axi_b_t            m_b,
   input  logic                       m_bvalid,
   output logic                       m_bready
);

   typedef enum logic [1:0] {
      ADDR_HS,
      WRITE,
      W_RESP
   } state_t;

   state_t state, state_nxt;

   logic [axi_pkg::ADDR_W-1:0] addr_reg;
   logic [axi_pkg::LEN_W-1:0]  length_reg;
   logic [axi_pkg::LEN_W-1:0]  beat_cnt;
   logic                       start;
   logic                       last_beat;
   logic                       w_xfer;
   logic                       b_xfer;

   assign start     = (state == ADDR_HS) & valid;
   assign last_beat = (beat_cnt == length_reg);
   assign w_xfer    = m_wvalid & m_wready;
   assign b_xfer    = m_bvalid & m_bready;

   // Address channel carries the captured request
   assign m_aw = '{addr:  addr_reg,
                   len:   length_reg,
                   size:  axi_pkg::AXI_SIZE,
                   burst: axi_pkg::AXI_BURST_INCR,
                   cache: axi_pkg::AXI_CACHE_VAL,
                   prot:  axi_pkg::AXI_PROT_VAL};

   // Native beats pass straight through to W
   assign m_w = '{data: wdata, strb: wstrb, last: last_beat};
   assign m_wvalid = (state == WRITE) & valid;
   assign ready    = (state == WRITE) & m_wready;

   // Response is always accepted
   assign m_bready = 1'b1;

   always_comb begin
      state_nxt = state;
      case (state)
         ADDR_HS: begin
            if (valid) begin
               state_nxt = WRITE;
            end
         end
         WRITE: begin
            if (w_xfer && last_beat) begin
               state_nxt = W_RESP;
            end
         end
         W_RESP: begin
            if (b_xfer) begin
               state_nxt = ADDR_HS;
            end
         end
         default: state_nxt = ADDR_HS;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= ADDR_HS;
         wr_ready <= 1'b1;
      end else begin
         state    <= state_nxt;
         wr_ready <= (state_nxt == ADDR_HS);
      end
   end

   // Request capture
   always_ff @(posedge clk) begin
      if (start) begin
         addr_reg   <= addr;
         length_reg <= length;
      end
   end

   // AW valid held from burst start until accepted, independent of W
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         m_awvalid <= 1'b0;
      end else if (start) begin
         m_awvalid <= 1'b1;
      end else if (m_awready) begin
         m_awvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_cnt <= '0;
      end else if (start) begin
         beat_cnt <= '0;
      end else if (w_xfer) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // Sticky until the next response arrives
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         error <= 1'b0;
      end else if ((state == W_RESP) && b_xfer) begin
         error <= (m_b.resp != axi_pkg::RESP_OKAY);
      end
   end

endmodule

/* iob2axi/iob2axi_rd.sv */
`timescale 1ns/1ns

module iob2axi_rd (
   input  logic                       clk,
   input  logic                       rst,

   // Burst control
   input  logic [axi_pkg::LEN_W-1:0]  length,
   output logic                       rd_ready,
   output logic                       error,

   // Native read side
   input  logic                       valid,
   input  logic [axi_pkg::ADDR_W-1:0] addr,
   output logic [axi_pkg::DATA_W-1:0] rdata,
   output logic                       beat_valid,

   // AXI read master
   output axi_pkg::axi_ax_t           m_ar,
   output logic                       m_arvalid,
   input  logic                       m_arready,
   input  axi_pkg::axi_r_t            m_r,
   input  logic                       m_rvalid,
   output logic                       m_rready
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA
   } state_t;

   state_t state, state_nxt;

   logic [axi_pkg::ADDR_W-1:0] addr_reg;
   logic [axi_pkg::LEN_W-1:0]  length_reg;
   logic                       start;
   logic                       r_xfer;
   logic                       beat_err;
   logic                       err_acc;

   assign start    = (state == IDLE) & valid;
   assign r_xfer   = m_rvalid & m_rready;
   assign beat_err = (m_r.resp != axi_pkg::RESP_OKAY);

   assign m_ar = '{addr:  addr_reg,
                   len:   length_reg,
                   size:  axi_pkg::AXI_SIZE,
                   burst: axi_pkg::AXI_BURST_INCR,
                   cache: axi_pkg::AXI_CACHE_VAL,
                   prot:  axi_pkg::AXI_PROT_VAL};

   assign m_arvalid = (state == ADDR);
   assign m_rready  = (state == DATA);

   // Native reader never stalls, so R beats go straight out
   assign beat_valid = m_rvalid & (state == DATA);
   assign rdata      = m_r.data;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (valid) begin
               state_nxt = ADDR;
            end
         end
         ADDR: begin
            if (m_arready) begin
               state_nxt = DATA;
            end
         end
         DATA: begin
            if (r_xfer && m_r.last) begin
               state_nxt = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= IDLE;
         rd_ready <= 1'b1;
      end else begin
         state    <= state_nxt;
         rd_ready <= (state_nxt == IDLE);
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         addr_reg   <= addr;
         length_reg <= length;
      end
   end

   // Error collected over the burst, published on the last beat
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         err_acc <= 1'b0;
         error   <= 1'b0;
      end else if (start) begin
         err_acc <= 1'b0;
      end else if (r_xfer) begin
         err_acc <= err_acc | beat_err;
         if (m_r.last) begin
            error <= err_acc | beat_err;
         end
      end
   end

endmodule

/* hw/iob2axi.sv */
`timescale 1ns/1ns

module iob2axi (
   input  logic                       clk,
   input  logic                       rst,

   // Write burst control and native beats
   input  logic [axi_pkg::LEN_W-1:0]  wr_length,
   output logic                       wr_ready,
   output logic                       wr_error,
   input  logic                       wr_valid,
   input  logic [axi_pkg::ADDR_W-1:0] wr_addr,
   input  logic [axi_pkg::DATA_W-1:0] wr_data,
   input  logic [axi_pkg::STRB_W-1:0] wr_strb,
   output logic                       wr_beat_ready,

   // Read burst control and native beats
   input  logic [axi_pkg::LEN_W-1:0]  rd_length,
   output logic                       rd_ready,
   output logic                       rd_error,
   input  logic                       rd_valid,
   input  logic [axi_pkg::ADDR_W-1:0] rd_addr,
   output logic [axi_pkg::DATA_W-1:0] rd_data,
   output logic                       rd_beat_valid,

   // AXI4 master port
   output axi_pkg::axi_ax_t           m_aw,
   output logic                       m_awvalid,
   input  logic                       m_awready,
   output axi_pkg::axi_w_t            m_w,
   output logic                       m_wvalid,
   input  logic                       m_wready,
   input  axi_pkg::axi_b_t            m_b,
   input  logic                       m_bvalid,
   output logic                       m_bready,
   output axi_pkg::axi_ax_t           m_ar,
   output logic                       m_arvalid,
   input  logic                       m_arready,
   input  axi_pkg::axi_r_t            m_r,
   input  logic                       m_rvalid,
   output logic                       m_rready
);

   // Write channels AW, W and B
   iob2axi_wr wr_inst (
      .clk       (clk),
      .rst       (rst),
      .length    (wr_length),
      .wr_ready  (wr_ready),
      .error     (wr_error),
      .valid     (wr_valid),
      .addr      (wr_addr),
      .wdata     (wr_data),
      .wstrb     (wr_strb),
      .ready     (wr_beat_ready),
      .m_aw      (m_aw),
      .m_awvalid (m_awvalid),
      .m_awready (m_awready),
      .m_w       (m_w),
      .m_wvalid  (m_wvalid),
      .m_wready  (m_wready),
      .m_b       (m_b),
      .m_bvalid  (m_bvalid),
      .m_bready  (m_bready)
   );

   // Read channels AR and R, independent of the write side
   iob2axi_rd rd_inst (
      .clk        (clk),
      .rst        (rst),
      .length     (rd_length),
      .rd_ready   (rd_ready),
      .error      (rd_error),
      .valid      (rd_valid),
      .addr       (rd_addr),
      .rdata      (rd_data),
      .beat_valid (rd_beat_valid),
      .m_ar       (m_ar),
      .m_arvalid  (m_arvalid),
      .m_arready  (m_arready),
      .m_r        (m_r),
      .m_rvalid   (m_rvalid),
      .m_rready   (m_rready)
   );

endmodule

/* tests/axi_mem_model.sv */
`timescale 1ns/1ns

// AXI slave memory, 256 words, readiness from random bits of the tb
module axi_mem_model (
   input  logic             clk,
   input  logic             rst,
   input  logic [3:0]       stall,
   input  axi_pkg::axi_ax_t aw,
   input  logic             awvalid,
   output logic             awready,
   input  axi_pkg::axi_w_t  w,
   input  logic             wvalid,
   output logic             wready,
   output axi_pkg::axi_b_t  b,
   output logic             bvalid,
   input  logic             bready,
   input  axi_pkg::axi_ax_t ar,
   input  logic             arvalid,
   output logic             arready,
   output axi_pkg::axi_r_t  r,
   output logic             rvalid,
   input  logic             rready
);

   logic [axi_pkg::DATA_W-1:0] mem [0:255];
   logic [7:0]                 w_idx;
   logic [7:0]                 r_idx;
   logic [7:0]                 r_cnt;
   logic [7:0]                 r_len;
   logic                       aw_done;
   logic                       w_err;
   logic                       r_busy;
   logic                       r_err;

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i) + 8'h33};
      end
   end

   assign awready = stall[0];
   // No W beat before its address
   assign wready  = stall[1] & aw_done;
   assign arready = stall[2] & ~r_busy;
   assign rvalid  = stall[3] & r_busy;

   assign b = '{resp: w_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY};
   assign r = '{data: r_err ? '0 : mem[r_idx],
                resp: r_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY,
                last: (r_cnt == r_len)};

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         aw_done <= 1'b0;
         w_err   <= 1'b0;
         w_idx   <= '0;
         bvalid  <= 1'b0;
      end else begin
         if (awvalid && awready) begin
            aw_done <= 1'b1;
            w_err   <= aw.addr[12];
            w_idx   <= aw.addr[9:2];
         end
         if (wvalid && wready) begin
            w_idx <= w_idx + 1'b1;
            if (w.last) begin
               aw_done <= 1'b0;
               bvalid  <= 1'b1;
            end
         end
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // Strobed write, nothing stored in the error region
   always @(posedge clk) begin
      if (wvalid && wready && !w_err) begin
         for (int i = 0; i < axi_pkg::STRB_W; i++) begin
            if (w.strb[i]) begin
               mem[w_idx][8*i +: 8] <= w.data[8*i +: 8];
            end
         end
      end
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         r_busy <= 1'b0;
         r_err  <= 1'b0;
         r_idx  <= '0;
         r_cnt  <= '0;
         r_len  <= '0;
      end else if (arvalid && arready) begin
         r_busy <= 1'b1;
         r_err  <= ar.addr[12];
         r_idx  <= ar.addr[9:2];
         r_cnt  <= '0;
         r_len  <= ar.len;
      end else if (rvalid && rready) begin
         r_idx <= r_idx + 1'b1;
         r_cnt <= r_cnt + 1'b1;
         if (r.last) begin
            r_busy <= 1'b0;
         end
      end
   end

endmodule

/* tests/tb_iob2axi.sv */
`timescale 1ns/1ns

module tb_iob2axi;

   localparam int BURSTS     = 40;
   // 16 beats at half throughput plus handshakes fits in 80 cycles
   localparam int MAX_CYCLES = BURSTS * 80;

   logic                       clk = 1'b0;
   logic                       rst;
   logic [axi_pkg::LEN_W-1:0]  wr_length;
   logic                       wr_ready;
   logic                       wr_error;
   logic                       wr_valid;
   logic [axi_pkg::ADDR_W-1:0] wr_addr;
   logic [axi_pkg::DATA_W-1:0] wr_data;
   logic [axi_pkg::STRB_W-1:0] wr_strb;
   logic                       wr_beat_ready;
   logic [axi_pkg::LEN_W-1:0]  rd_length;
   logic                       rd_ready;
   logic                       rd_error;
   logic                       rd_valid;
   logic [axi_pkg::ADDR_W-1:0] rd_addr;
   logic [axi_pkg::DATA_W-1:0] rd_data;
   logic                       rd_beat_valid;
   axi_pkg::axi_ax_t           m_aw;
   logic                       m_awvalid;
   logic                       m_awready;
   axi_pkg::axi_w_t            m_w;
   logic                       m_wvalid;
   logic                       m_wready;
   axi_pkg::axi_b_t            m_b;
   logic                       m_bvalid;
   logic                       m_bready;
   axi_pkg::axi_ax_t           m_ar;
   logic                       m_arvalid;
   logic                       m_arready;
   axi_pkg::axi_r_t            m_r;
   logic                       m_rvalid;
   logic                       m_rready;

   logic [3:0]                 stall;
   logic [31:0]                lfsr_state;
   logic [axi_pkg::DATA_W-1:0] ref_mem [0:255];
   axi_pkg::axi_ax_t           exp_aw;
   axi_pkg::axi_ax_t           exp_ar;
   logic [7:0]                 rd_idx;
   logic                       rd_exp_err = 1'b0;
   int                         exp_beats = 0;
   int                         w_beats = 0;
   int                         aw_cnt = 0;
   int                         ar_cnt = 0;
   int                         r_beats = 0;
   int                         cycles = 0;

   iob2axi iob2axi_inst (.*);

   axi_mem_model mem_inst (
      .clk     (clk),
      .rst     (rst),
      .stall   (stall),
      .aw      (m_aw),
      .awvalid (m_awvalid),
      .awready (m_awready),
      .w       (m_w),
      .wvalid  (m_wvalid),
      .wready  (m_wready),
      .b       (m_b),
      .bvalid  (m_bvalid),
      .bready  (m_bready),
      .ar      (m_ar),
      .arvalid (m_arvalid),
      .arready (m_arready),
      .r       (m_r),
      .rvalid  (m_rvalid),
      .rready  (m_rready)
   );

   always #10 clk = ~clk;

   // Galois LFSR, one step per bit returned
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
         bits = {bits[30:0], lfsr_state[0]};
      end
      return bits;
   endfunction

   function automatic logic [axi_pkg::DATA_W-1:0] fill_word(input int i);
      return {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i) + 8'h33};
   endfunction

   // Drive point after the next rising edge, with a fresh stall pattern
   task automatic next_cycle();
      @(posedge clk);
      #2;
      stall = 4'(rand_bits(4));
   endtask

   task automatic fail_stop();
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input logic [axi_pkg::DATA_W-1:0] exp,
                             input logic [axi_pkg::DATA_W-1:0] got);
      if (got !== exp) begin
         $display("Error %s expected %h got %h", name, exp, got);
         fail_stop();
      end
   endtask

   task automatic check_resp(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("Error %s expected %h got %h", name, exp, got);
         fail_stop();
      end
   endtask

   task automatic check_beats(input string name, input int exp, input int got);
      if (got != exp) begin
         $display("Error %s expected %h got %h", name, exp, got);
         fail_stop();
      end
   endtask

   task automatic check_ax(input string name, input axi_pkg::axi_ax_t exp,
                           input axi_pkg::axi_ax_t got);
      if (got !== exp) begin
         $display("Error %s expected %h got %h", name, exp, got);
         fail_stop();
      end
   endtask

   // Handshakes are stable mid-cycle, ahead of the edge that takes them
   always @(negedge clk) begin
      if (m_awvalid && m_awready) begin
         aw_cnt++;
         check_ax("m_aw", exp_aw, m_aw);
      end
      if (m_wvalid && m_wready) begin
         w_beats++;
         check_resp("m_w.last", w_beats == exp_beats, m_w.last);
      end
      if (m_arvalid && m_arready) begin
         ar_cnt++;
         check_ax("m_ar", exp_ar, m_ar);
      end
      if (rd_beat_valid) begin
         if (!rd_exp_err) begin
            check_data("rd_data", ref_mem[rd_idx + r_beats], rd_data);
         end
         r_beats++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: bursts did not complete");
         fail_stop();
      end
   end

   task automatic write_burst(input logic [7:0] idx, input logic err, input int len);
      int   sent;
      int   b;
      logic taken;
      sent      = 0;
      w_beats   = 0;
      aw_cnt    = 0;
      exp_beats = len + 1;
      next_cycle();
      wr_addr   = {19'b0, err, 2'b0, idx, 2'b0};
      wr_length = 8'(len);
      wr_data   = rand_bits(32);
      wr_strb   = 4'(rand_bits(4));
      wr_valid  = 1'b1;
      exp_aw = '{addr: wr_addr, len: wr_length, size: axi_pkg::AXI_SIZE,
                 burst: axi_pkg::AXI_BURST_INCR, cache: axi_pkg::AXI_CACHE_VAL,
                 prot: axi_pkg::AXI_PROT_VAL};
      while (sent <= len) begin
         @(negedge clk);
         taken = wr_beat_ready;
         if (taken && !err) begin
            for (b = 0; b < axi_pkg::STRB_W; b++) begin
               if (wr_strb[b]) begin
                  ref_mem[idx + sent][8*b +: 8] = wr_data[8*b +: 8];
               end
            end
         end
         next_cycle();
         if (taken) begin
            sent++;
            wr_data = rand_bits(32);
            wr_strb = 4'(rand_bits(4));
         end
      end
      wr_valid = 1'b0;
      while (!wr_ready) begin
         @(negedge clk);
      end
      check_beats("aw transfers", 1, aw_cnt);
      check_beats("w transfers", len + 1, w_beats);
      check_resp("wr_error", err, wr_error);
   endtask

   task automatic read_burst(input logic [7:0] idx, input logic err, input int len);
      r_beats    = 0;
      ar_cnt     = 0;
      rd_idx     = idx;
      rd_exp_err = err;
      next_cycle();
      rd_addr   = {19'b0, err, 2'b0, idx, 2'b0};
      rd_length = 8'(len);
      rd_valid  = 1'b1;
      exp_ar = '{addr: rd_addr, len: rd_length, size: axi_pkg::AXI_SIZE,
                 burst: axi_pkg::AXI_BURST_INCR, cache: axi_pkg::AXI_CACHE_VAL,
                 prot: axi_pkg::AXI_PROT_VAL};
      // Request held until the engine is ready again, stalls keep changing
      next_cycle();
      while (!rd_ready) begin
         next_cycle();
      end
      rd_valid = 1'b0;
      check_beats("ar transfers", 1, ar_cnt);
      check_beats("rd beats", len + 1, r_beats);
      check_resp("rd_error", err, rd_error);
   endtask

   initial begin
      logic [7:0] idx;
      logic       err;
      int         len;
      int         n;
      lfsr_state = 32'h5aaa;
      rst        = 1'b1;
      stall      = '0;
      wr_length  = '0;
      wr_valid   = 1'b0;
      wr_addr    = '0;
      wr_data    = '0;
      wr_strb    = '0;
      rd_length  = '0;
      rd_valid   = 1'b0;
      rd_addr    = '0;
      for (n = 0; n < 256; n++) begin
         ref_mem[n] = fill_word(n);
      end
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;
      @(negedge clk);
      check_resp("wr_ready", 1'b1, wr_ready);
      check_resp("rd_ready", 1'b1, rd_ready);
      check_resp("m_awvalid", 1'b0, m_awvalid);
      check_resp("m_wvalid", 1'b0, m_wvalid);
      check_resp("m_arvalid", 1'b0, m_arvalid);
      check_resp("wr_error", 1'b0, wr_error);
      check_resp("rd_error", 1'b0, rd_error);

      // Mixed bursts, about one in eight to the error region
      for (n = 0; n < BURSTS; n++) begin
         len = int'(rand_bits(4));
         idx = 8'(rand_bits(8) % 240);
         err = (rand_bits(3) == 0);
         if (rand_bits(1) == 1) begin
            write_burst(idx, err, len);
         end else begin
            read_burst(idx, err, len);
         end
      end

      // Whole memory read back against the reference
      for (n = 0; n < 16; n++) begin
         read_burst(8'(n * 16), 1'b0, 15);
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

/* vlog.f */
common/axi_pkg.sv
iob2axi/iob2axi_wr.sv
iob2axi/iob2axi_rd.sv
hw/iob2axi.sv
tests/axi_mem_model.sv
tests/tb_iob2axi.sv
